// ==== src/acc_pkg.sv ====
/*
 * shared definitions for the accelerator shell
 * APB register offsets, fixed AXI ID,
 * engine to memory master request and response structs
 */
package acc_pkg;

   ////////////////////
   // APB register map
   ////////////////////

   // low eight address bits only
   localparam logic [7:0] reg_base_off   = 8'h50;
   localparam logic [7:0] reg_ctrl_off   = 8'h54;
   localparam logic [7:0] reg_status_off = 8'h58;

   ////////////////////
   // AXI constants
   ////////////////////

   // single outstanding access, so one tag is enough
   localparam logic [3:0] axi_tag = 4'h1;

   ////////////////////
   // engine <-> master
   ////////////////////

   // request, held stable while req is high
   typedef struct packed {
      logic        wr;
      logic [31:0] addr;
      logic [31:0] wdata;
   } mem_req_t;

   // response, valid while ack is high
   typedef struct packed {
      logic [31:0] rdata;
      logic        err;
   } mem_rsp_t;

endpackage

// ==== src/apb_ctrl_regs.sv ====
/*
 * APB slave for the shell configuration
 * base offset, soft start and read-only busy flag
 * pslverr on unmapped offsets
 */
module apb_ctrl_regs (
   input  logic        clk,
   input  logic        reset_pe,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   input  logic        busy,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic [31:0] base_addr,
   output logic        start_bit
);

   logic [31:0] base_q;
   logic        start_q;
   logic [7:0]  off;
   logic        hit;
   logic        setup_ph;
   logic        access_ph;

   assign off       = paddr[7:0];
   assign setup_ph  = psel && !penable;
   assign access_ph = psel && penable;
   assign hit       = (off == acc_pkg::reg_base_off) ||
                      (off == acc_pkg::reg_ctrl_off) ||
                      (off == acc_pkg::reg_status_off);

   // no wait states
   assign pready    = 1'b1;
   assign base_addr = base_q;
   assign start_bit = start_q;

   always_ff @(posedge clk) begin
      if (reset_pe) begin
         base_q  <= '0;
         start_q <= 1'b0;
         prdata  <= '0;
         pslverr <= 1'b0;
      end else begin
         // error flag set at setup edge, so it shows in the access phase only
         pslverr <= setup_ph && !hit;

         // read data captured one phase early
         if (setup_ph && !pwrite) begin
            case (off)
               acc_pkg::reg_base_off:   prdata <= base_q;
               acc_pkg::reg_ctrl_off:   prdata <= {31'b0, start_q};
               acc_pkg::reg_status_off: prdata <= {31'b0, busy};
               default:                 prdata <= '0;
            endcase
         end

         // writes land on the access edge, status is read only
         if (access_ph && pwrite) begin
            case (off)
               acc_pkg::reg_base_off: base_q  <= pwdata;
               acc_pkg::reg_ctrl_off: start_q <= pwdata[0];
               default: ;
            endcase
         end
      end
   end

   ////////////////////
   // checks
   ////////////////////

   slverr_in_access: assert property (@(posedge clk) disable iff (reset_pe)
      pslverr |-> (psel && penable))
      else $error("pslverr outside the APB access phase");

endmodule

// ==== src/core_reset_seq.sv ====
/*
 * start detection and multicycle core reset
 * core_en follows the released reset until software clears start
 */
module core_reset_seq #(
   parameter int RESET_CYCLES = 4
) (
   input  logic clk,
   input  logic reset_pe,
   input  logic start_bit,
   input  logic busy,
   output logic core_reset,
   output logic core_en
);

   localparam int CNT_W = $clog2(RESET_CYCLES + 1);

   logic             started;
   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk) begin
      if (reset_pe) begin
         started    <= 1'b0;
         core_reset <= 1'b0;
         core_en    <= 1'b0;
         cnt        <= '0;
      end else if (start_bit && !started) begin
         // new run, reset is seen from the next cycle on
         started    <= 1'b1;
         core_reset <= 1'b1;
         core_en    <= 1'b0;
         cnt        <= '0;
      end else if (core_reset) begin
         if (cnt == CNT_W'(RESET_CYCLES - 1)) begin
            core_reset <= 1'b0;
            core_en    <= 1'b1;
         end else begin
            cnt <= cnt + CNT_W'(1);
         end
      end else if (!start_bit && !busy) begin
         // rearm for the next start
         started <= 1'b0;
         core_en <= 1'b0;
      end
   end

   core_reset_len: assert property (@(posedge clk) disable iff (reset_pe)
      $rose(core_reset) |-> ##[1:RESET_CYCLES] !core_reset)
      else $error("core_reset held longer than RESET_CYCLES");

endmodule

// ==== src/kernel_engine.sv ====
/*
 * stand-in compute core
 * reads WORD_COUNT words from offset zero, adds KERNEL_INC,
 * writes each result at DST_OFFSET, one four-phase exchange per access
 */
module kernel_engine #(
   parameter int          WORD_COUNT = 8,
   parameter logic [31:0] KERNEL_INC = 32'd1,
   parameter logic [31:0] DST_OFFSET = 32'h100
) (
   input  logic              clk,
   input  logic              core_reset,
   input  logic              core_en,
   input  logic              ack,
   input  acc_pkg::mem_rsp_t rsp,
   output logic              req,
   output acc_pkg::mem_req_t req_data,
   output logic              busy
);

   localparam int IDX_W = $clog2(WORD_COUNT + 1);

   typedef enum logic [1:0] {
      st_idle,
      st_req,
      st_rel,
      st_done
   } state_t;

   state_t           state;
   logic [IDX_W-1:0] idx;
   logic             busy_q;
   logic             fin_q;
   logic             last_idx;

   assign last_idx = (idx == IDX_W'(WORD_COUNT - 1));

   // high from the first reset cycle on
   assign busy = core_reset | busy_q;

   always_ff @(posedge clk) begin
      if (core_reset) begin
         state  <= st_idle;
         req    <= 1'b0;
         idx    <= '0;
         fin_q  <= 1'b0;
         busy_q <= 1'b1;
      end else if (!core_en) begin
         // enable stands in for the clock, hold everything quiet
         state  <= st_idle;
         req    <= 1'b0;
         busy_q <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               req_data <= '{wr: 1'b0, addr: 32'(idx) << 2, wdata: '0};
               req      <= 1'b1;
               state    <= st_req;
            end
            st_req: begin
               if (ack) begin
                  req   <= 1'b0;
                  state <= st_rel;
                  if (!req_data.wr) begin
                     if (rsp.err) begin
                        fin_q  <= 1'b1;
                        busy_q <= 1'b0;
                     end else begin
                        // compute step, the result goes straight out
                        req_data <= '{wr: 1'b1,
                                      addr: DST_OFFSET + (32'(idx) << 2),
                                      wdata: rsp.rdata + KERNEL_INC};
                     end
                  end else if (rsp.err || last_idx) begin
                     fin_q  <= 1'b1;
                     busy_q <= 1'b0;
                  end else begin
                     idx      <= idx + IDX_W'(1);
                     req_data <= '{wr: 1'b0,
                                   addr: (32'(idx) + 32'd1) << 2,
                                   wdata: '0};
                  end
               end
            end
            st_rel: begin
               // wait for ack low before the next request
               if (!ack) begin
                  if (fin_q) begin
                     state <= st_done;
                  end else begin
                     req   <= 1'b1;
                     state <= st_req;
                  end
               end
            end
            st_done: state <= st_done;
            default: state <= st_idle;
         endcase
      end
   end

   req_hold: assert property (@(posedge clk) disable iff (core_reset || !core_en)
      (req && !ack) |=> (req && $stable(req_data)))
      else $error("request changed before ack");

endmodule

// ==== src/axi_mem_master.sv ====
/*
 * four-phase request to single-beat AXI master
 * aw and w issued together, then b, or ar then r
 * base_addr is added to every address
 */
module axi_mem_master (
   input  logic              clk,
   input  logic              reset_pe,
   input  logic [31:0]       base_addr,
   input  logic              req,
   input  acc_pkg::mem_req_t req_data,
   output logic              ack,
   output acc_pkg::mem_rsp_t rsp,

   output logic [3:0]        awid,
   output logic [31:0]       awaddr,
   output logic [7:0]        awlen,
   output logic [2:0]        awsize,
   output logic [1:0]        awburst,
   output logic              awvalid,
   input  logic              awready,

   output logic [31:0]       wdata,
   output logic [3:0]        wstrb,
   output logic              wlast,
   output logic              wvalid,
   input  logic              wready,

   input  logic [1:0]        bresp,
   input  logic              bvalid,
   output logic              bready,

   output logic [3:0]        arid,
   output logic [31:0]       araddr,
   output logic [7:0]        arlen,
   output logic [2:0]        arsize,
   output logic [1:0]        arburst,
   output logic              arvalid,
   input  logic              arready,

   input  logic [31:0]       rdata,
   input  logic [1:0]        rresp,
   input  logic              rvalid,
   output logic              rready
);

   typedef enum logic [2:0] {
      st_idle,
      st_wr,
      st_b,
      st_rd,
      st_r,
      st_ack
   } state_t;

   state_t      state;
   logic [31:0] addr_q;
   logic [31:0] wdata_q;
   logic        aw_left;
   logic        w_left;

   // single 32-bit INCR beats
   assign awid    = acc_pkg::axi_tag;
   assign arid    = acc_pkg::axi_tag;
   assign awlen   = 8'd0;
   assign arlen   = 8'd0;
   assign awsize  = 3'd2;
   assign arsize  = 3'd2;
   assign awburst = 2'b01;
   assign arburst = 2'b01;
   assign wstrb   = 4'hf;
   assign wlast   = 1'b1;
   assign awaddr  = addr_q;
   assign araddr  = addr_q;
   assign wdata   = wdata_q;

   // aw and w may complete in either order
   assign aw_left = awvalid && !awready;
   assign w_left  = wvalid && !wready;

   always_ff @(posedge clk) begin
      if (reset_pe) begin
         state   <= st_idle;
         ack     <= 1'b0;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
         arvalid <= 1'b0;
         bready  <= 1'b0;
         rready  <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (req) begin
                  awvalid <= req_data.wr;
                  wvalid  <= req_data.wr;
                  arvalid <= !req_data.wr;
                  state   <= req_data.wr ? st_wr : st_rd;
               end
            end
            st_wr: begin
               if (awvalid && awready) awvalid <= 1'b0;
               if (wvalid && wready) wvalid <= 1'b0;
               if (!aw_left && !w_left) begin
                  bready <= 1'b1;
                  state  <= st_b;
               end
            end
            st_b: begin
               if (bvalid) begin
                  bready <= 1'b0;
                  ack    <= 1'b1;
                  state  <= st_ack;
               end
            end
            st_rd: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  rready  <= 1'b1;
                  state   <= st_r;
               end
            end
            st_r: begin
               if (rvalid) begin
                  rready <= 1'b0;
                  ack    <= 1'b1;
                  state  <= st_ack;
               end
            end
            st_ack: begin
               if (!req) begin
                  ack   <= 1'b0;
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // address and data, plus the response captured with ack
   always_ff @(posedge clk) begin
      if (state == st_idle && req) begin
         addr_q  <= req_data.addr + base_addr;
         wdata_q <= req_data.wdata;
      end
      if (state == st_b && bvalid) begin
         rsp <= '{rdata: '0, err: (bresp != 2'b00)};
      end
      if (state == st_r && rvalid) begin
         rsp <= '{rdata: rdata, err: (rresp != 2'b00)};
      end
   end

   ////////////////////
   // AXI valid rules
   ////////////////////

   aw_hold: assert property (@(posedge clk) disable iff (reset_pe)
      (awvalid && !awready) |=> awvalid)
      else $error("awvalid dropped before awready");

   w_hold: assert property (@(posedge clk) disable iff (reset_pe)
      (wvalid && !wready) |=> wvalid)
      else $error("wvalid dropped before wready");

   ar_hold: assert property (@(posedge clk) disable iff (reset_pe)
      (arvalid && !arready) |=> arvalid)
      else $error("arvalid dropped before arready");

endmodule

// ==== src/acc_wrapper.sv ====
/*
 * accelerator shell top level
 * APB register file, core reset sequencer,
 * kernel engine and AXI memory master
 */
module acc_wrapper #(
   parameter int          RESET_CYCLES = 4,
   parameter int          WORD_COUNT   = 8,
   parameter logic [31:0] KERNEL_INC   = 32'd1,
   parameter logic [31:0] DST_OFFSET   = 32'h100
) (
   input  logic        clk,
   input  logic        reset_pe,

   // APB configuration port
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,

   // AXI write address and data
   output logic [3:0]  m_axi_awid,
   output logic [31:0] m_axi_awaddr,
   output logic [7:0]  m_axi_awlen,
   output logic [2:0]  m_axi_awsize,
   output logic [1:0]  m_axi_awburst,
   output logic        m_axi_awvalid,
   input  logic        m_axi_awready,
   output logic [31:0] m_axi_wdata,
   output logic [3:0]  m_axi_wstrb,
   output logic        m_axi_wlast,
   output logic        m_axi_wvalid,
   input  logic        m_axi_wready,
   input  logic [1:0]  m_axi_bresp,
   input  logic        m_axi_bvalid,
   output logic        m_axi_bready,

   // AXI read
   output logic [3:0]  m_axi_arid,
   output logic [31:0] m_axi_araddr,
   output logic [7:0]  m_axi_arlen,
   output logic [2:0]  m_axi_arsize,
   output logic [1:0]  m_axi_arburst,
   output logic        m_axi_arvalid,
   input  logic        m_axi_arready,
   input  logic [31:0] m_axi_rdata,
   input  logic [1:0]  m_axi_rresp,
   input  logic        m_axi_rvalid,
   output logic        m_axi_rready,

   output logic        busy
);

   logic [31:0]       base_addr;
   logic              start_bit;
   logic              core_reset;
   logic              core_en;
   logic              req;
   logic              ack;
   acc_pkg::mem_req_t req_data;
   acc_pkg::mem_rsp_t rsp;

   apb_ctrl_regs u_regs (
      .clk       (clk),
      .reset_pe  (reset_pe),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .busy      (busy),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .base_addr (base_addr),
      .start_bit (start_bit)
   );

   core_reset_seq #(
      .RESET_CYCLES (RESET_CYCLES)
   ) u_rst_seq (
      .clk        (clk),
      .reset_pe   (reset_pe),
      .start_bit  (start_bit),
      .busy       (busy),
      .core_reset (core_reset),
      .core_en    (core_en)
   );

   kernel_engine #(
      .WORD_COUNT (WORD_COUNT),
      .KERNEL_INC (KERNEL_INC),
      .DST_OFFSET (DST_OFFSET)
   ) u_engine (
      .clk        (clk),
      .core_reset (core_reset),
      .core_en    (core_en),
      .ack        (ack),
      .rsp        (rsp),
      .req        (req),
      .req_data   (req_data),
      .busy       (busy)
   );

   axi_mem_master u_master (
      .clk       (clk),
      .reset_pe  (reset_pe),
      .base_addr (base_addr),
      .req       (req),
      .req_data  (req_data),
      .ack       (ack),
      .rsp       (rsp),
      .awid      (m_axi_awid),
      .awaddr    (m_axi_awaddr),
      .awlen     (m_axi_awlen),
      .awsize    (m_axi_awsize),
      .awburst   (m_axi_awburst),
      .awvalid   (m_axi_awvalid),
      .awready   (m_axi_awready),
      .wdata     (m_axi_wdata),
      .wstrb     (m_axi_wstrb),
      .wlast     (m_axi_wlast),
      .wvalid    (m_axi_wvalid),
      .wready    (m_axi_wready),
      .bresp     (m_axi_bresp),
      .bvalid    (m_axi_bvalid),
      .bready    (m_axi_bready),
      .arid      (m_axi_arid),
      .araddr    (m_axi_araddr),
      .arlen     (m_axi_arlen),
      .arsize    (m_axi_arsize),
      .arburst   (m_axi_arburst),
      .arvalid   (m_axi_arvalid),
      .arready   (m_axi_arready),
      .rdata     (m_axi_rdata),
      .rresp     (m_axi_rresp),
      .rvalid    (m_axi_rvalid),
      .rready    (m_axi_rready)
   );

endmodule

// ==== sim/axi_mem_model.sv ====
/*
 * AXI slave memory for the shell testbench
 * sparse word storage, ready delays of 0 to 3 cycles,
 * write address log for the destination checks
 */
module axi_mem_model (
   input  logic        clk,
   input  logic        reset_pe,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [31:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready
);

   logic [31:0] mem [logic [31:0]];
   logic [31:0] wr_log [$];

   // driven 1 unit after the rising edge
   logic        aw_rdy = 1'b0;
   logic        w_rdy  = 1'b0;
   logic        ar_rdy = 1'b0;
   logic        b_vld  = 1'b0;
   logic        r_vld  = 1'b0;
   logic [31:0] r_data = '0;
   int          aw_cnt = -1;
   int          w_cnt  = -1;
   int          ar_cnt = -1;
   logic        aw_got = 1'b0;
   logic        w_got  = 1'b0;

   assign awready = aw_rdy;
   assign wready  = w_rdy;
   assign arready = ar_rdy;
   assign bvalid  = b_vld;
   assign rvalid  = r_vld;
   assign rdata   = r_data;
   // always OKAY
   assign bresp   = 2'b00;
   assign rresp   = 2'b00;

   // unwritten words, pattern over the whole address
   function automatic logic [31:0] peek(input logic [31:0] addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
   endfunction

   task automatic poke(input logic [31:0] addr, input logic [31:0] data);
      mem[addr] = data;
   endtask

   task automatic clear_log();
      wr_log.delete();
   endtask

   function automatic int logged_writes();
      return wr_log.size();
   endfunction

   function automatic logic [31:0] logged_addr(input int i);
      return wr_log[i];
   endfunction

   // one ready line, random stall once valid shows up
   task automatic pace_ready(input logic valid, input logic taken,
                             inout logic ready, inout int cnt);
      if (taken) begin
         ready = 1'b0;
         cnt   = -1;
      end else if (valid && !ready) begin
         if (cnt < 0) begin
            cnt = $urandom_range(3, 0);
         end
         if (cnt == 0) begin
            ready = 1'b1;
         end else begin
            cnt = cnt - 1;
         end
      end
   endtask

   initial begin
      logic        aw_hs;
      logic        w_hs;
      logic        ar_hs;
      logic        b_hs;
      logic        r_hs;
      logic        in_reset;
      logic [31:0] aw_q;
      logic [31:0] w_q;
      logic [31:0] ar_q;
      forever begin
         // handshakes that complete on the coming edge
         @(negedge clk);
         in_reset = reset_pe;
         aw_hs    = awvalid && aw_rdy;
         w_hs     = wvalid && w_rdy;
         ar_hs    = arvalid && ar_rdy;
         b_hs     = b_vld && bready;
         r_hs     = r_vld && rready;
         if (aw_hs) aw_q = awaddr;
         if (w_hs) w_q = wdata;
         if (ar_hs) ar_q = araddr;
         @(posedge clk);
         #1;
         if (in_reset) begin
            aw_rdy = 1'b0;
            w_rdy  = 1'b0;
            ar_rdy = 1'b0;
            b_vld  = 1'b0;
            r_vld  = 1'b0;
            aw_got = 1'b0;
            w_got  = 1'b0;
            aw_cnt = -1;
            w_cnt  = -1;
            ar_cnt = -1;
         end else begin
            pace_ready(awvalid, aw_hs, aw_rdy, aw_cnt);
            pace_ready(wvalid, w_hs, w_rdy, w_cnt);
            pace_ready(arvalid, ar_hs, ar_rdy, ar_cnt);
            aw_got = aw_got || aw_hs;
            w_got  = w_got || w_hs;
            if (b_hs) b_vld = 1'b0;
            // address and data both in, commit and answer
            if (aw_got && w_got && !b_vld) begin
               mem[aw_q] = w_q;
               wr_log.push_back(aw_q);
               aw_got = 1'b0;
               w_got  = 1'b0;
               b_vld  = 1'b1;
            end
            if (r_hs) r_vld = 1'b0;
            if (ar_hs) begin
               r_data = peek(ar_q);
               r_vld  = 1'b1;
            end
         end
      end
   end

endmodule

// ==== sim/tb_acc_wrapper.sv ====
/*
 * testbench for the accelerator shell
 * clock and reset, APB transfer tasks, AXI memory beside the DUT,
 * reference model, destination compare process, timeout
 */
module tb_acc_wrapper;

   localparam int          RESET_CYCLES   = 4;
   localparam int          WORD_COUNT     = 8;
   localparam logic [31:0] KERNEL_INC     = 32'd3;
   localparam logic [31:0] DST_OFFSET     = 32'h100;
   localparam int          RUNS           = 2;
   localparam int          TIMEOUT_CYCLES = RUNS * WORD_COUNT * 40 + 200;

   logic        clk;
   logic        reset_pe;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [3:0]  m_axi_awid;
   logic [31:0] m_axi_awaddr;
   logic [7:0]  m_axi_awlen;
   logic [2:0]  m_axi_awsize;
   logic [1:0]  m_axi_awburst;
   logic        m_axi_awvalid;
   logic        m_axi_awready;
   logic [31:0] m_axi_wdata;
   logic [3:0]  m_axi_wstrb;
   logic        m_axi_wlast;
   logic        m_axi_wvalid;
   logic        m_axi_wready;
   logic [1:0]  m_axi_bresp;
   logic        m_axi_bvalid;
   logic        m_axi_bready;
   logic [3:0]  m_axi_arid;
   logic [31:0] m_axi_araddr;
   logic [7:0]  m_axi_arlen;
   logic [2:0]  m_axi_arsize;
   logic [1:0]  m_axi_arburst;
   logic        m_axi_arvalid;
   logic        m_axi_arready;
   logic [31:0] m_axi_rdata;
   logic [1:0]  m_axi_rresp;
   logic        m_axi_rvalid;
   logic        m_axi_rready;
   logic        busy;

   // error counts, one per process
   int          reg_errs     = 0;
   int          mem_errs     = 0;
   int          order_errs   = 0;
   int          axi_errs     = 0;
   int          runs_started = 0;
   int          runs_checked = 0;
   int          cycles       = 0;
   int          busy_cycles  = 0;
   logic        req_seen     = 1'b0;

   // current run, read by the compare process
   logic [31:0] run_base;
   logic [31:0] src_words [$];
   event        run_done;

   acc_wrapper #(
      .RESET_CYCLES (RESET_CYCLES),
      .WORD_COUNT   (WORD_COUNT),
      .KERNEL_INC   (KERNEL_INC),
      .DST_OFFSET   (DST_OFFSET)
   ) DUT (.*);

   axi_mem_model mem_model (
      .clk      (clk),
      .reset_pe (reset_pe),
      .awaddr   (m_axi_awaddr),
      .awvalid  (m_axi_awvalid),
      .awready  (m_axi_awready),
      .wdata    (m_axi_wdata),
      .wvalid   (m_axi_wvalid),
      .wready   (m_axi_wready),
      .bresp    (m_axi_bresp),
      .bvalid   (m_axi_bvalid),
      .bready   (m_axi_bready),
      .araddr   (m_axi_araddr),
      .arvalid  (m_axi_arvalid),
      .arready  (m_axi_arready),
      .rdata    (m_axi_rdata),
      .rresp    (m_axi_rresp),
      .rvalid   (m_axi_rvalid),
      .rready   (m_axi_rready)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   ////////////////////
   // reference model
   ////////////////////

   // destination word for one source word
   function automatic logic [31:0] expected_word(input logic [31:0] src);
      return src + KERNEL_INC;
   endfunction

   // where result i lands for a given base
   function automatic logic [31:0] result_addr(input logic [31:0] base, input int i);
      return base + DST_OFFSET + 32'(i) * 32'd4;
   endfunction

   ////////////////////
   // APB and checks
   ////////////////////

   task automatic match_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
         else begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
            reg_errs++;
         end
   endtask

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
         else begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
            axi_errs++;
         end
   endtask

   task automatic require(input bit ok, input string what);
      assert (ok)
         else begin
            $display("ERROR: %s", what);
            reg_errs++;
         end
   endtask

   // setup phase, access phase, then idle
   task automatic apb_xfer(input logic wr, input logic [7:0] off, input logic [31:0] data,
                           output logic [31:0] rd, output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = {24'h0, off};
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      match_value("pready", 32'(pready), 32'h1);
      rd  = prdata;
      err = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_mapped(input logic [7:0] off, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, off, data, rd, err);
      require(!err, $sformatf("pslverr on a write to mapped offset 0x%02h", off));
   endtask

   task automatic read_and_compare(input logic [7:0] off, input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b0, off, 32'h0, rd, err);
      match_value($sformatf("prdata at 0x%02h", off), rd, exp);
      require(!err, $sformatf("pslverr on a read from mapped offset 0x%02h", off));
   endtask

   // load sources, restart the core, poll until busy falls
   task automatic run_kernel(input logic [31:0] base);
      logic [31:0] rd;
      logic        err;
      src_words.delete();
      for (int i = 0; i < WORD_COUNT; i++) begin
         src_words.push_back($urandom);
         mem_model.poke(base + 32'(i) * 32'd4, src_words[i]);
      end
      mem_model.clear_log();
      run_base = base;
      write_mapped(acc_pkg::reg_base_off, base);
      write_mapped(acc_pkg::reg_ctrl_off, 32'd0);
      write_mapped(acc_pkg::reg_ctrl_off, 32'd1);
      apb_xfer(1'b0, acc_pkg::reg_status_off, 32'h0, rd, err);
      require(rd[0] === 1'b1, "status does not show busy right after start");
      match_value("busy", 32'(busy), 32'h1);
      while (rd[0] === 1'b1) begin
         apb_xfer(1'b0, acc_pkg::reg_status_off, 32'h0, rd, err);
      end
      match_value("busy", 32'(busy), 32'h0);
      runs_started++;
      -> run_done;
      wait (runs_checked == runs_started);
   endtask

   ////////////////////
   // compare process
   ////////////////////

   initial begin
      logic [31:0] addr;
      logic [31:0] got;
      logic [31:0] wa;
      forever begin
         @(run_done);
         for (int i = 0; i < WORD_COUNT; i++) begin
            addr = result_addr(run_base, i);
            got  = mem_model.peek(addr);
            assert (got === expected_word(src_words[i]))
               else begin
                  $display("MISMATCH mem[0x%08h]: got 0x%08h, expected 0x%08h",
                           addr, got, expected_word(src_words[i]));
                  mem_errs++;
               end
         end
         assert (mem_model.logged_writes() == WORD_COUNT)
            else begin
               $display("ERROR: %0d AXI writes in a run of %0d words",
                        mem_model.logged_writes(), WORD_COUNT);
               mem_errs++;
            end
         for (int i = 0; i < mem_model.logged_writes(); i++) begin
            wa = mem_model.logged_addr(i);
            assert (wa >= result_addr(run_base, 0) && wa < result_addr(run_base, WORD_COUNT))
               else begin
                  $display("ERROR: write at 0x%08h lies outside the destination", wa);
                  mem_errs++;
               end
         end
         runs_checked++;
      end
   end

   // every beat is a single 32-bit INCR transfer with the shell tag
   always @(negedge clk) begin
      if (m_axi_awvalid === 1'b1) begin
         check_field("m_axi_awid", 32'(m_axi_awid), 32'(acc_pkg::axi_tag));
         check_field("m_axi_awlen", 32'(m_axi_awlen), 32'h0);
         check_field("m_axi_awsize", 32'(m_axi_awsize), 32'h2);
         check_field("m_axi_awburst", 32'(m_axi_awburst), 32'h1);
      end
      if (m_axi_wvalid === 1'b1) begin
         check_field("m_axi_wstrb", 32'(m_axi_wstrb), 32'hf);
         check_field("m_axi_wlast", 32'(m_axi_wlast), 32'h1);
      end
      if (m_axi_arvalid === 1'b1) begin
         check_field("m_axi_arid", 32'(m_axi_arid), 32'(acc_pkg::axi_tag));
         check_field("m_axi_arlen", 32'(m_axi_arlen), 32'h0);
         check_field("m_axi_arsize", 32'(m_axi_arsize), 32'h2);
         check_field("m_axi_arburst", 32'(m_axi_arburst), 32'h1);
      end
   end

   // no AXI request while the core is still held in reset
   always @(negedge clk) begin
      if (reset_pe || !busy) begin
         busy_cycles = 0;
         req_seen    = 1'b0;
      end else if (m_axi_arvalid || m_axi_awvalid) begin
         if (!req_seen) begin
            assert (busy_cycles >= RESET_CYCLES)
               else begin
                  $display("ERROR: first AXI request only %0d cycles after busy rose",
                           busy_cycles);
                  order_errs++;
               end
         end
         req_seen = 1'b1;
      end else if (!req_seen) begin
         busy_cycles++;
      end
   end

   // run limit
   initial begin
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: no result after %0d cycles", cycles);
      $display("errors: %0d register, %0d memory, %0d ordering, %0d AXI field",
               reg_errs, mem_errs, order_errs, axi_errs);
      $display("Simulation FAILED");
      $finish;
   end

   ////////////////////
   // test sequence
   ////////////////////

   initial begin
      logic [31:0] rd;
      logic        err;
      void'($urandom(24));
      reset_pe = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      repeat (10) @(posedge clk);
      #1;
      reset_pe = 1'b0;

      // registers come out of reset cleared
      read_and_compare(acc_pkg::reg_base_off, 32'h0);
      read_and_compare(acc_pkg::reg_ctrl_off, 32'h0);
      read_and_compare(acc_pkg::reg_status_off, 32'h0);

      write_mapped(acc_pkg::reg_base_off, 32'h1234_5670);
      read_and_compare(acc_pkg::reg_base_off, 32'h1234_5670);

      // unmapped offsets answer with an error and change nothing
      apb_xfer(1'b1, 8'h5c, 32'hffff_ffff, rd, err);
      require(err === 1'b1, "no pslverr on a write to unmapped offset 0x5c");
      apb_xfer(1'b0, 8'h10, 32'h0, rd, err);
      require(err === 1'b1, "no pslverr on a read from unmapped offset 0x10");
      read_and_compare(acc_pkg::reg_base_off, 32'h1234_5670);
      read_and_compare(acc_pkg::reg_ctrl_off, 32'h0);

      // second run restarts through start 0 then 1
      run_kernel(32'h0001_0000);
      run_kernel(32'h0002_4000);

      $display("errors: %0d register, %0d memory, %0d ordering, %0d AXI field",
               reg_errs, mem_errs, order_errs, axi_errs);
      if (reg_errs + mem_errs + order_errs + axi_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
src/acc_pkg.sv
src/apb_ctrl_regs.sv
src/core_reset_seq.sv
src/kernel_engine.sv
src/axi_mem_master.sv
src/acc_wrapper.sv
sim/axi_mem_model.sv
sim/tb_acc_wrapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the accelerator shell testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_acc_wrapper
OBJ_DIR=obj_dir

verilator --binary --timing --assert -j 0 --top-module "$TOP" -Mdir "$OBJ_DIR" -f build.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$("./$OBJ_DIR/V$TOP")
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^Simulation PASSED$"; then
   exit 0
fi
exit 1
